//--- hw/accel_pkg.sv
package accel_pkg;

    localparam int WORD_BITS = 16;
    localparam int ADDR_BITS = 12;
    localparam int DEPTH     = 1 << ADDR_BITS;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Codes 4 to 7 are undefined
    typedef enum logic [2:0] {
        OP_COPY = 3'd0,
        OP_SWAP = 3'd1,
        OP_ADD  = 3'd2,
        OP_MUL  = 3'd3
    } op_e;

    // Count of zero means no words
    typedef struct packed {
        op_e   op;
        addr_t a_src;
        addr_t b_src;
        addr_t count;
    } instr_t;

    typedef struct packed {
        op_e   op;
        addr_t a_src;
        addr_t b_src;
        addr_t count;
    } job_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } operand_pair_t;

    typedef struct packed {
        word_t uni;
        word_t wei;
    } result_pair_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } wr_port_t;

endpackage

//--- hw/accel_top.sv
`timescale 1ns/1ps

module accel_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  accel_pkg::instr_t        instr,
    output logic                     ack,
    output logic                     done,
    input  accel_pkg::wr_port_t      a_wr,
    input  accel_pkg::wr_port_t      b_wr,
    input  accel_pkg::addr_t         out_rd_addr,
    output accel_pkg::result_pair_t  out_rd_data
);

    // Controller to fetch and writer
    logic                      start;
    accel_pkg::job_t           job;
    logic                      last_written;

    // Fetch to global buffers
    logic                      rd_en;
    accel_pkg::addr_t          a_rd_addr;
    accel_pkg::addr_t          b_rd_addr;
    accel_pkg::word_t          a_rd_data;
    accel_pkg::word_t          b_rd_data;

    // Processing lane
    logic                      pair_valid;
    accel_pkg::op_e            op;
    accel_pkg::operand_pair_t  operands;
    logic                      res_valid;
    accel_pkg::result_pair_t   res;

    // Output buffer write side
    logic                      wr_en;
    accel_pkg::addr_t          wr_addr;
    accel_pkg::result_pair_t   wr_data;

    assign operands = '{a: a_rd_data, b: b_rd_data};

    main_ctrl u_main_ctrl (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .ack          (ack),
        .done         (done),
        .start        (start),
        .job          (job),
        .last_written (last_written)
    );

    // fetch_last is only used inside the fetch engine
    stream_fetch u_stream_fetch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .job        (job),
        .rd_en      (rd_en),
        .a_rd_addr  (a_rd_addr),
        .b_rd_addr  (b_rd_addr),
        .pair_valid (pair_valid),
        .op         (op),
        .fetch_last ()
    );

    sram_1r1w #(.payload_t(accel_pkg::word_t)) gbuf_a (
        .clk   (clk),
        .rst   (rst),
        .we    (a_wr.en),
        .waddr (a_wr.addr),
        .wdata (a_wr.data),
        .re    (rd_en),
        .raddr (a_rd_addr),
        .rdata (a_rd_data)
    );

    sram_1r1w #(.payload_t(accel_pkg::word_t)) gbuf_b (
        .clk   (clk),
        .rst   (rst),
        .we    (b_wr.en),
        .waddr (b_wr.addr),
        .wdata (b_wr.data),
        .re    (rd_en),
        .raddr (b_rd_addr),
        .rdata (b_rd_data)
    );

    pe_lane u_pe_lane (
        .clk        (clk),
        .rst        (rst),
        .pair_valid (pair_valid),
        .operands   (operands),
        .op         (op),
        .res_valid  (res_valid),
        .res        (res)
    );

    result_writer u_result_writer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .count        (job.count),
        .res_valid    (res_valid),
        .res          (res),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .last_written (last_written)
    );

    // Read port is always enabled for readback
    sram_1r1w #(.payload_t(accel_pkg::result_pair_t)) out_buf (
        .clk   (clk),
        .rst   (rst),
        .we    (wr_en),
        .waddr (wr_addr),
        .wdata (wr_data),
        .re    (1'b1),
        .raddr (out_rd_addr),
        .rdata (out_rd_data)
    );

endmodule

//--- hw/main_ctrl.sv
`timescale 1ns/1ps

module main_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  accel_pkg::instr_t  instr,
    output logic               ack,
    output logic               done,
    output logic               start,
    output accel_pkg::job_t    job,
    input  logic               last_written
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e state;
    logic   accept;
    logic   op_ok;
    logic   launch;

    // Strobes are only taken while idle
    assign accept = (state == ST_IDLE) && instr_valid;

    assign op_ok = instr.op inside {accel_pkg::OP_COPY, accel_pkg::OP_SWAP,
                                    accel_pkg::OP_ADD, accel_pkg::OP_MUL};

    assign launch = accept && op_ok && (instr.count != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            done  <= 1'b0;
            start <= 1'b0;
        end else begin
            ack   <= accept;
            start <= launch;
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        done  <= 1'b0;
                        state <= ST_BUSY;
                    end else if (accept && op_ok) begin
                        // Empty job is finished at once
                        done <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (last_written) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            job <= '{
                op:    instr.op,
                a_src: instr.a_src,
                b_src: instr.b_src,
                count: instr.count
            };
        end
    end

endmodule

//--- hw/pe_lane.sv
`timescale 1ns/1ps

module pe_lane (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pair_valid,
    input  accel_pkg::operand_pair_t  operands,
    input  accel_pkg::op_e            op,
    output logic                      res_valid,
    output accel_pkg::result_pair_t   res
);

    logic                                s1_valid;
    accel_pkg::operand_pair_t            s1_pair;
    accel_pkg::op_e                      s1_op;
    logic [2*accel_pkg::WORD_BITS-1:0]   prod;
    accel_pkg::result_pair_t             calc;

    assign prod = (2*accel_pkg::WORD_BITS)'(s1_pair.a) * (2*accel_pkg::WORD_BITS)'(s1_pair.b);

    always_comb begin
        case (s1_op)
            accel_pkg::OP_SWAP: calc = '{uni: s1_pair.b, wei: s1_pair.a};
            accel_pkg::OP_ADD:  calc = '{uni: s1_pair.a + s1_pair.b, wei: s1_pair.a - s1_pair.b};
            accel_pkg::OP_MUL: begin
                calc = '{uni: prod[accel_pkg::WORD_BITS-1:0],
                         wei: prod[2*accel_pkg::WORD_BITS-1:accel_pkg::WORD_BITS]};
            end
            default:            calc = '{uni: s1_pair.a, wei: s1_pair.b};
        endcase
    end

    // Valid bits follow the data through both stages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= pair_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_pair <= operands;
        s1_op   <= op;
        res     <= calc;
    end

endmodule

//--- hw/result_writer.sv
`timescale 1ns/1ps

module result_writer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  accel_pkg::addr_t         count,
    input  logic                     res_valid,
    input  accel_pkg::result_pair_t  res,
    output logic                     wr_en,
    output accel_pkg::addr_t         wr_addr,
    output accel_pkg::result_pair_t  wr_data,
    output logic                     last_written
);

    accel_pkg::addr_t next_addr;
    accel_pkg::addr_t count_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_en        <= 1'b0;
            last_written <= 1'b0;
            next_addr    <= '0;
            count_q      <= '0;
        end else begin
            wr_en        <= res_valid;
            last_written <= res_valid && (next_addr == count_q - 1'b1);
            if (start) begin
                next_addr <= '0;
                count_q   <= count;
            end else if (res_valid) begin
                next_addr <= next_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            wr_addr <= next_addr;
            wr_data <= res;
        end
    end

endmodule

//--- hw/sram_1r1w.sv
`timescale 1ns/1ps

module sram_1r1w #(
    parameter type payload_t = accel_pkg::word_t
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  accel_pkg::addr_t  waddr,
    input  payload_t          wdata,
    input  logic              re,
    input  accel_pkg::addr_t  raddr,
    output payload_t          rdata
);

    payload_t mem [accel_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read that holds its value while re is low
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- hw/stream_fetch.sv
`timescale 1ns/1ps

module stream_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  accel_pkg::job_t   job,
    output logic              rd_en,
    output accel_pkg::addr_t  a_rd_addr,
    output accel_pkg::addr_t  b_rd_addr,
    output logic              pair_valid,
    output accel_pkg::op_e    op,
    output logic              fetch_last
);

    // Words still to read, including the one on the bus now
    accel_pkg::addr_t remaining;

    assign fetch_last = rd_en && (remaining == accel_pkg::ADDR_BITS'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_en      <= 1'b0;
            remaining  <= '0;
            pair_valid <= 1'b0;
        end else begin
            // RAM data appears one cycle after the read
            pair_valid <= rd_en;
            if (start) begin
                rd_en     <= (job.count != '0);
                remaining <= job.count;
            end else if (rd_en) begin
                remaining <= remaining - 1'b1;
                if (fetch_last) begin
                    rd_en <= 1'b0;
                end
            end
        end
    end

    // Addresses wrap modulo DEPTH
    always_ff @(posedge clk) begin
        if (start) begin
            a_rd_addr <= job.a_src;
            b_rd_addr <= job.b_src;
            op        <= job.op;
        end else if (rd_en) begin
            a_rd_addr <= a_rd_addr + 1'b1;
            b_rd_addr <= b_rd_addr + 1'b1;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_accel -o tb_accel

out=$(./obj_dir/tb_accel)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- sim.f
hw/accel_pkg.sv
hw/sram_1r1w.sv
hw/main_ctrl.sv
hw/stream_fetch.sv
hw/pe_lane.sv
hw/result_writer.sv
hw/accel_top.sv
sim/tb_accel.sv

//--- sim/accel_testdata.txt
# name op a_src b_src count checksum
# op 0 copy, 1 swap, 2 add, 3 mul, 4 to 7 undefined; checksum is hex XOR of out_buf 0 to count-1
copy_basic   0    0    1 3 05c12f94
swap_basic   1 4093 4090 3 9e89ae2d
add_wrap     2 4094 4093 4 e12028f0
mul_wrap     3 4095 4092 3 4c8fe44e
busy_copy    0 4088 4089 3 75f69f1c
undef_op     5    0    0 3 75f69f1c
zero_count   2    0    0 0 00000000

//--- sim/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;

    localparam int MAX_TESTS  = 16;
    localparam int FILL_WORDS = 256;

    logic                     clk;
    logic                     rst;
    logic                     instr_valid;
    accel_pkg::instr_t        instr;
    logic                     ack;
    logic                     done;
    accel_pkg::wr_port_t      a_wr;
    accel_pkg::wr_port_t      b_wr;
    accel_pkg::addr_t         out_rd_addr;
    accel_pkg::result_pair_t  out_rd_data;

    // Copies of both global buffers and of what out_buf should hold
    accel_pkg::word_t         a_mem [accel_pkg::DEPTH];
    accel_pkg::word_t         b_mem [accel_pkg::DEPTH];
    accel_pkg::result_pair_t  out_model [accel_pkg::DEPTH];
    int                       written_max;

    string                    t_name  [MAX_TESTS];
    int                       t_op    [MAX_TESTS];
    int                       t_a_src [MAX_TESTS];
    int                       t_b_src [MAX_TESTS];
    int                       t_count [MAX_TESTS];
    logic [31:0]              t_sum   [MAX_TESTS];
    int                       num_tests;

    int                       errors;
    int                       tests_failed;
    int                       cycles;
    int                       cycle_limit;
    logic                     counting;

    accel_top UUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ack         (ack),
        .done        (done),
        .a_wr        (a_wr),
        .b_wr        (b_wr),
        .out_rd_addr (out_rd_addr),
        .out_rd_data (out_rd_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (counting) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d cycles, the tests did not finish", cycles);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd5 + 32'd1;
    endfunction

    // Result pair by the opcode rules with 16-bit wraparound
    function automatic accel_pkg::result_pair_t model_pair(input int op,
                                                           input accel_pkg::word_t a,
                                                           input accel_pkg::word_t b);
        logic [31:0]             prod;
        accel_pkg::result_pair_t r;
        prod = {16'h0000, a} * {16'h0000, b};
        case (op)
            0:       r = '{uni: a, wei: b};
            1:       r = '{uni: b, wei: a};
            2:       r = '{uni: a + b, wei: a - b};
            default: r = '{uni: prod[15:0], wei: prod[31:16]};
        endcase
        return r;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        string       name;
        int          op;
        int          a_src;
        int          b_src;
        int          count;
        logic [31:0] sum;
        fd = $fopen("sim/accel_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/accel_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %d %d %d %d %h", name, op, a_src, b_src, count, sum);
                    if (n == 6) begin
                        t_name[num_tests]  = name;
                        t_op[num_tests]    = op;
                        t_a_src[num_tests] = a_src;
                        t_b_src[num_tests] = b_src;
                        t_count[num_tests] = count;
                        t_sum[num_tests]   = sum;
                        cycle_limit += count + 20;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Fill starts 8 words below the top so jobs can wrap
    task automatic fill_buffers();
        logic [31:0]      s;
        accel_pkg::addr_t ad;
        int               k;
        s = 32'h25b20857;
        for (k = 0; k < FILL_WORDS; k++) begin
            s = lcg_next(s);
            ad = accel_pkg::addr_t'(accel_pkg::DEPTH - 8 + k);
            a_mem[ad] = s[31:16];
            b_mem[ad] = s[15:0];
            @(posedge clk);
            a_wr <= '{en: 1'b1, addr: ad, data: s[31:16]};
            b_wr <= '{en: 1'b1, addr: ad, data: s[15:0]};
        end
        @(posedge clk);
        a_wr <= '0;
        b_wr <= '0;
    endtask

    task automatic run_test(input int idx);
        accel_pkg::instr_t cmd;
        accel_pkg::instr_t busy_cmd;
        logic              launch;
        logic              done_seen;
        int                waited;
        int                errs_before;
        int                i;
        logic [31:0]       sum;
        accel_pkg::addr_t  ad_a;
        accel_pkg::addr_t  ad_b;
        errs_before = errors;
        cmd.op    = accel_pkg::op_e'(3'(t_op[idx]));
        cmd.a_src = accel_pkg::addr_t'(t_a_src[idx]);
        cmd.b_src = accel_pkg::addr_t'(t_b_src[idx]);
        cmd.count = accel_pkg::addr_t'(t_count[idx]);
        busy_cmd  = '{op: accel_pkg::OP_ADD, a_src: 12'd5, b_src: 12'd7, count: 12'd2};
        launch    = (t_op[idx] <= 3) && (t_count[idx] != 0);

        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= cmd;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_value(t_name[idx], "ack", 32'd1, 32'(ack));
        check_value(t_name[idx], "done at ack", 32'(!launch), 32'(done));

        if (launch) begin
            waited    = 0;
            done_seen = 1'b0;
            while (!done_seen && waited < t_count[idx] + 6) begin
                @(posedge clk);
                // A second strobe while busy
                instr_valid <= (waited == 1);
                instr       <= busy_cmd;
                @(negedge clk);
                waited++;
                check_value(t_name[idx], "ack while busy", 32'd0, 32'(ack));
                done_seen = done;
            end
            if (!done_seen) begin
                $display("%s: done did not rise within %0d cycles of ack",
                         t_name[idx], t_count[idx] + 6);
                errors++;
            end
            for (i = 0; i < t_count[idx]; i++) begin
                ad_a = accel_pkg::addr_t'(t_a_src[idx] + i);
                ad_b = accel_pkg::addr_t'(t_b_src[idx] + i);
                out_model[i] = model_pair(t_op[idx], a_mem[ad_a], b_mem[ad_b]);
            end
            if (t_count[idx] > written_max) begin
                written_max = t_count[idx];
            end
        end else begin
            repeat (8) begin
                @(negedge clk);
                check_value(t_name[idx], "ack after pulse", 32'd0, 32'(ack));
                check_value(t_name[idx], "done level", 32'd1, 32'(done));
            end
        end

        // Read back everything written so far
        sum = '0;
        for (i = 0; i < written_max; i++) begin
            @(posedge clk);
            out_rd_addr <= accel_pkg::addr_t'(i);
            @(posedge clk);
            @(negedge clk);
            check_value(t_name[idx], "result pair", out_model[i], out_rd_data);
            if (i < t_count[idx]) begin
                sum ^= out_rd_data;
            end
        end
        if (t_count[idx] > 0) begin
            check_value(t_name[idx], "checksum", t_sum[idx], sum);
        end

        if (errors == errs_before) begin
            $display("test %s passed", t_name[idx]);
        end else begin
            $display("test %s failed with %0d errors", t_name[idx], errors - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        a_wr         = '0;
        b_wr         = '0;
        out_rd_addr  = '0;
        written_max  = 0;
        num_tests    = 0;
        errors       = 0;
        tests_failed = 0;
        cycles       = 0;
        cycle_limit  = 300;
        counting     = 1'b0;

        read_tests();
        if (num_tests == 0) begin
            $display("No tests were read from the data file");
            errors++;
        end

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        fill_buffers();

        counting = 1'b1;
        for (int idx = 0; idx < num_tests; idx++) begin
            run_test(idx);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, num_tests - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
